// ==== rvCore.f ====
+incdir+verilog
verilog/rvIsaPkg.sv
verilog/rvCtrlPkg.sv
verilog/regFile.sv
verilog/instrDecoder.sv
verilog/aluUnit.sv
verilog/rvCore.sv
testbench/rvCoreTb.sv

// ==== testbench/rvCoreTb.sv ====
// Testbench for the single-cycle core
// Program memory, instruction-set reference model, compare process and watchdog

`timescale 1ns/1ps
`default_nettype none

`include "rvParams.svh"

module rvCoreTb import rvIsaPkg::*, rvCtrlPkg::*; ();

  localparam int clkPeriod   = 40;
  localparam int driveDelay  = 2;
  localparam int memWords    = 1024;
  localparam int randomOps   = 60;
  localparam int stallCycles = 6;

  logic                   clk;
  logic                   rst;
  logic                   run;
  logic [`XLEN-1:0]       instrAddr;
  logic [`XLEN-1:0]       instr;
  logic [`REG_ADDR_W-1:0] testReg;
  logic [`XLEN-1:0]       testData;
  logic                   illegalSeen;

  // Program memory and the end address of each program segment
  logic [`XLEN-1:0] progMem [memWords];
  int               progLen;
  int               segEnds [$];

  // Shadow architectural state
  logic [`XLEN-1:0] shadowRegs [`REG_COUNT];
  logic [`XLEN-1:0] shadowPc;

  logic checking;
  logic scanning;
  logic progReady;
  int   errorCount;
  int   checkCount;
  int   limitCycles;

  rvCore rvCore_i (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .instrAddr   (instrAddr),
    .instr       (instr),
    .testReg     (testReg),
    .testData    (testData),
    .illegalSeen (illegalSeen)
  );

  // Fetch answered in the same cycle
  assign instr = progMem[instrAddr[11:2]];

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // ISA arithmetic, alt selects SUB or SRA
  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [31:0]        res;
    sa = a;
    sb = b;
    case (f3)
      3'b000:  res = alt ? (a - b) : (a + b);
      3'b001:  res = a << b[4:0];
      3'b010:  res = (sa < sb) ? 32'd1 : 32'd0;
      3'b011:  res = (a < b) ? 32'd1 : 32'd0;
      3'b100:  res = a ^ b;
      3'b101: begin
        if (alt) res = sa >>> b[4:0];
        else res = a >> b[4:0];
      end
      3'b110:  res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  // Executes one instruction on the shadow registers and PC
  function automatic void refStep(input logic [31:0] w, output logic isIllegal);
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] nextPc;
    logic        wr;
    rd        = w[11:7];
    f3        = w[14:12];
    a         = shadowRegs[w[19:15]];
    b         = shadowRegs[w[24:20]];
    res       = '0;
    wr        = 1'b0;
    isIllegal = 1'b0;
    nextPc    = shadowPc + 32'd4;
    case (w[6:0])
      OPC_OP: begin
        wr  = 1'b1;
        res = aluRef(f3, w[30], a, b);
      end
      OPC_OP_IMM: begin
        // Only SRAI reads bit 30, elsewhere it is immediate data
        wr  = 1'b1;
        res = aluRef(f3, w[30] && (f3 == 3'b101), a, {{20{w[31]}}, w[31:20]});
      end
      OPC_LUI: begin
        wr  = 1'b1;
        res = {w[31:12], 12'b0};
      end
      OPC_BRANCH: begin
        if ((f3 == F3_BNE) ? (a != b) : (a == b))
          nextPc = shadowPc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      end
      OPC_JAL: begin
        wr     = 1'b1;
        res    = shadowPc + 32'd4;
        nextPc = shadowPc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      default: isIllegal = 1'b1;
    endcase
    if (wr && (rd != 5'd0)) shadowRegs[rd] = res;
    shadowPc = nextPc;
  endfunction

  // Instruction encoders
  function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] luiWord(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic logic [31:0] branchWord(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] jalWord(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic void appendInstr(input logic [31:0] word);
    progMem[progLen] = word;
    progLen++;
  endfunction

  // LUI plus ADDI seeds, then random register and immediate ALU ops
  task automatic buildRandomAlu();
    logic [31:0] rnd;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    for (int r = 1; r < 16; r++) begin
      rnd = $urandom();
      appendInstr(luiWord(rnd[31:12], 5'(r)));
      appendInstr(iTypeWord(rnd[11:0], 5'(r), F3_ADD_SUB, 5'(r)));
    end
    for (int n = 0; n < randomOps; n++) begin
      rnd = $urandom();
      rd  = rnd[4:0];
      rs1 = rnd[9:5];
      rs2 = rnd[14:10];
      f3  = rnd[17:15];
      if (rnd[19]) begin
        // Shift immediates carry shamt and the arithmetic bit
        case (f3)
          F3_SLL:     imm = {7'b0, rs2};
          F3_SRL_SRA: imm = {1'b0, rnd[18], 5'b0, rs2};
          default:    imm = rnd[31:20];
        endcase
        appendInstr(iTypeWord(imm, rs1, f3, rd));
      end else begin
        f7 = (rnd[18] && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA)) ? 7'b0100000 : 7'b0;
        appendInstr(rTypeWord(f7, rs2, rs1, f3, rd));
      end
    end
    segEnds.push_back(progLen * 4);
  endtask

  // Writes to x0, then a chain where each result feeds the next
  task automatic buildX0AndRaw();
    appendInstr(iTypeWord(12'd123, 5'd0, F3_ADD_SUB, 5'd0));
    appendInstr(rTypeWord(7'b0, 5'd2, 5'd1, F3_ADD_SUB, 5'd0));
    appendInstr(luiWord(20'hfffff, 5'd0));
    appendInstr(iTypeWord(12'd7, 5'd0, F3_ADD_SUB, 5'd5));
    appendInstr(rTypeWord(7'b0, 5'd5, 5'd5, F3_ADD_SUB, 5'd6));
    appendInstr(rTypeWord(7'b0100000, 5'd6, 5'd5, F3_ADD_SUB, 5'd7));
    appendInstr(rTypeWord(7'b0100000, 5'd5, 5'd7, F3_SRL_SRA, 5'd8));
    appendInstr(rTypeWord(7'b0, 5'd7, 5'd5, F3_SLTU, 5'd9));
    appendInstr(rTypeWord(7'b0, 5'd5, 5'd7, F3_SLT, 5'd10));
    segEnds.push_back(progLen * 4);
  endtask

  // Branches taken and not taken, then JAL with and without a link
  task automatic buildBranches();
    appendInstr(iTypeWord(12'd5, 5'd0, F3_ADD_SUB, 5'd1));
    appendInstr(iTypeWord(12'd5, 5'd0, F3_ADD_SUB, 5'd2));
    appendInstr(iTypeWord(12'd9, 5'd0, F3_ADD_SUB, 5'd3));
    appendInstr(branchWord(13'd8, 5'd2, 5'd1, F3_BEQ));
    appendInstr(iTypeWord(12'd41, 5'd0, F3_ADD_SUB, 5'd10));
    appendInstr(branchWord(13'd8, 5'd3, 5'd1, F3_BEQ));
    appendInstr(iTypeWord(12'd2, 5'd0, F3_ADD_SUB, 5'd11));
    appendInstr(branchWord(13'd8, 5'd3, 5'd1, F3_BNE));
    appendInstr(iTypeWord(12'd3, 5'd0, F3_ADD_SUB, 5'd12));
    appendInstr(branchWord(13'd8, 5'd2, 5'd1, F3_BNE));
    appendInstr(iTypeWord(12'd4, 5'd0, F3_ADD_SUB, 5'd13));
    appendInstr(jalWord(21'd12, 5'd14));
    appendInstr(iTypeWord(12'd5, 5'd0, F3_ADD_SUB, 5'd15));
    appendInstr(iTypeWord(12'd6, 5'd0, F3_ADD_SUB, 5'd16));
    appendInstr(iTypeWord(12'd7, 5'd0, F3_ADD_SUB, 5'd17));
    appendInstr(jalWord(21'd8, 5'd0));
    appendInstr(iTypeWord(12'd8, 5'd0, F3_ADD_SUB, 5'd18));
    segEnds.push_back(progLen * 4);
  endtask

  // Two segments around a stall, the second holds an unsupported LOAD
  task automatic buildStallAndIllegal();
    appendInstr(iTypeWord(12'd100, 5'd0, F3_ADD_SUB, 5'd20));
    appendInstr(iTypeWord(12'hfff, 5'd20, F3_ADD_SUB, 5'd21));
    segEnds.push_back(progLen * 4);
    appendInstr(rTypeWord(7'b0, 5'd21, 5'd20, F3_ADD_SUB, 5'd22));
    appendInstr({12'habc, 5'd1, 3'b010, 5'd22, 7'b0000011});
    appendInstr(iTypeWord(12'd1, 5'd22, F3_ADD_SUB, 5'd23));
    segEnds.push_back(progLen * 4);
  endtask

  // Compare process, sampled at the falling edge
  always @(negedge clk) begin
    logic illegalExp;
    if (checking) begin
      checkEq(instrAddr, shadowPc, "instrAddr against model PC");
      if (run) begin
        refStep(progMem[shadowPc[11:2]], illegalExp);
        checkEq(32'(illegalSeen), 32'(illegalExp), "illegalSeen");
      end
      if (scanning)
        checkEq(testData, shadowRegs[testReg], $sformatf("register x%0d", testReg));
    end
  end

  task automatic runProgram(input logic [31:0] endPc);
    run = 1'b1;
    while (shadowPc != endPc) begin
      @(posedge clk);
      #driveDelay;
    end
    run = 1'b0;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #driveDelay;
    end
  endtask

  // Walk the debug port over every register
  task automatic scanRegisters();
    scanning = 1'b1;
    for (int i = 0; i < `REG_COUNT; i++) begin
      testReg = 5'(i);
      @(posedge clk);
      #driveDelay;
    end
    scanning = 1'b0;
  endtask

  // Watchdog sized from the program length and the scan cycles
  initial begin
    wait (progReady === 1'b1);
    #(limitCycles * clkPeriod);
    $display("Timeout: the core did not finish within %0d cycles and appears hung",
             limitCycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    rst        = 1'b1;
    run        = 1'b0;
    testReg    = '0;
    checking   = 1'b0;
    scanning   = 1'b0;
    progReady  = 1'b0;
    errorCount = 0;
    checkCount = 0;
    progLen    = 0;
    shadowPc   = `RESET_PC;
    void'($urandom(32'h0ce8ae52));
    for (int i = 0; i < `REG_COUNT; i++) shadowRegs[i] = '0;
    // Unused words decode as opcode 0, an unsupported no-op
    for (int i = 0; i < memWords; i++) progMem[i] = 32'(i) << 7;
    buildRandomAlu();
    buildX0AndRaw();
    buildBranches();
    buildStallAndIllegal();
    limitCycles = 2 + progLen + 64 +
                  (segEnds.size() + 1) * (`REG_COUNT + stallCycles + 1);
    progReady = 1'b1;

    repeat (2) @(posedge clk);
    #driveDelay;
    rst      = 1'b0;
    checking = 1'b1;
    scanRegisters();
    foreach (segEnds[i]) begin
      runProgram(segEnds[i]);
      idleCycles(stallCycles);
      scanRegisters();
    end

    $display("Run complete: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/aluUnit.sv ====
// Combinational ALU
// Arithmetic, logic, shifts, compares and operand B pass-through

`timescale 1ns/1ps
`default_nettype none

`include "rvParams.svh"

module aluUnit import rvCtrlPkg::*; (
  input  logic [`XLEN-1:0] opA,
  input  logic [`XLEN-1:0] opB,
  input  aluOpE            aluOp,
  output logic [`XLEN-1:0] result,
  output logic             isEqual
);

  // Only the low five bits of B count for shifts
  logic [4:0] shamt;

  assign shamt = opB[4:0];

  always_comb begin
    case (aluOp)
      ALU_ADD:   result = opA + opB;
      ALU_SUB:   result = opA - opB;
      ALU_AND:   result = opA & opB;
      ALU_OR:    result = opA | opB;
      ALU_XOR:   result = opA ^ opB;
      ALU_SLL:   result = opA << shamt;
      ALU_SRL:   result = opA >> shamt;
      ALU_SRA:   result = $unsigned($signed(opA) >>> shamt);
      // Compares give 0 or 1
      ALU_SLT:   result = {{(`XLEN-1){1'b0}}, ($signed(opA) < $signed(opB))};
      ALU_SLTU:  result = {{(`XLEN-1){1'b0}}, (opA < opB)};
      ALU_PASSB: result = opB;
      default:   result = '0;
    endcase
  end

  // Branch condition source, independent of aluOp
  assign isEqual = (opA == opB);

endmodule

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
// Instruction decoder
// Builds the control bundle and immediate from one instruction word

`timescale 1ns/1ps
`default_nettype none

`include "rvParams.svh"

module instrDecoder import rvIsaPkg::*, rvCtrlPkg::*; (
  input  instrU instr,
  output ctrlT  ctrl
);

  logic [`XLEN-1:0] iImm;
  logic [`XLEN-1:0] bImm;
  logic [`XLEN-1:0] uImm;
  logic [`XLEN-1:0] jImm;

  // funct3 plus instruction bit 30 to an ALU operation
  // Bit 30 picks SUB only for register ops, on immediates it is part of imm
  function automatic aluOpE aluFromFunct(
    input logic [2:0] funct3,
    input logic       bit30,
    input logic       isImm
  );
    aluOpE op;
    case (funct3)
      F3_ADD_SUB: op = (bit30 && !isImm) ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = bit30 ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      default:    op = ALU_AND;
    endcase
    return op;
  endfunction

  // Sign extended immediates, one per format
  assign iImm = {{(`XLEN-12){instr.iType.imm[11]}}, instr.iType.imm};

  assign bImm = {{(`XLEN-13){instr.bType.imm12}}, instr.bType.imm12,
                 instr.bType.imm11, instr.bType.imm10_5,
                 instr.bType.imm4_1, 1'b0};

  assign uImm = {instr.uType.imm31_12, 12'b0};

  assign jImm = {{(`XLEN-21){instr.jType.imm20}}, instr.jType.imm20,
                 instr.jType.imm19_12, instr.jType.imm11,
                 instr.jType.imm10_1, 1'b0};

  always_comb begin
    ctrl = '0;
    // Register fields sit in the same place in every format
    ctrl.rs1   = instr.rType.rs1;
    ctrl.rs2   = instr.rType.rs2;
    ctrl.rd    = instr.rType.rd;
    ctrl.aluOp = ALU_ADD;

    case (instr.rType.opcode)
      OPC_OP: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluFromFunct(instr.rType.funct3, instr.rType.funct7[5], 1'b0);
      end
      OPC_OP_IMM: begin
        // Shift amount is the low five bits of the immediate
        ctrl.imm      = iImm;
        ctrl.useImm   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluFromFunct(instr.iType.funct3, instr.iType.imm[10], 1'b1);
      end
      OPC_LUI: begin
        ctrl.imm      = uImm;
        ctrl.useImm   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = ALU_PASSB;
      end
      OPC_BRANCH: begin
        // ALU compares rs1 with rs2, the core reads isEqual
        ctrl.imm      = bImm;
        ctrl.isBranch = 1'b1;
        ctrl.branchNe = (instr.bType.funct3 == F3_BNE);
        ctrl.aluOp    = ALU_SUB;
      end
      OPC_JAL: begin
        ctrl.imm      = jImm;
        ctrl.isJal    = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: begin
        // Unsupported opcode becomes a no-op
        ctrl.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
// Integer register file
// Two operand read ports, one debug read port, one write port

`timescale 1ns/1ps
`default_nettype none

`include "rvParams.svh"

module regFile (
  input  logic                   clk,
  input  logic                   rst,
  // Write port
  input  logic                   regWrite,
  input  logic [`REG_ADDR_W-1:0] regW,
  input  logic [`XLEN-1:0]       wData,
  // Operand reads
  input  logic [`REG_ADDR_W-1:0] regA,
  input  logic [`REG_ADDR_W-1:0] regB,
  output logic [`XLEN-1:0]       aData,
  output logic [`XLEN-1:0]       bData,
  // Debug read
  input  logic [`REG_ADDR_W-1:0] regTest,
  output logic [`XLEN-1:0]       testData
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  // Clear the whole array on reset so every register starts at zero
  // Entry 0 is skipped on writes and stays zero forever
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite && (regW != '0)) begin
      regs[regW] <= wData;
    end
  end

  // Asynchronous reads
  // A write is seen here in the cycle after its edge
  assign aData    = regs[regA];
  assign bData    = regs[regB];
  assign testData = regs[regTest];

endmodule

`default_nettype wire

// ==== verilog/rvCore.sv ====
// Single-cycle RV32I subset core
// PC, next-PC select, operand and writeback muxing, debug register read

`timescale 1ns/1ps
`default_nettype none

`include "rvParams.svh"

module rvCore import rvCtrlPkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  // Core advances only while high
  input  logic                   run,
  // Instruction fetch, answered in the same cycle
  output logic [`XLEN-1:0]       instrAddr,
  input  logic [`XLEN-1:0]       instr,
  // Debug register read
  input  logic [`REG_ADDR_W-1:0] testReg,
  output logic [`XLEN-1:0]       testData,
  // Current instruction is not supported
  output logic                   illegalSeen
);

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] pcPlus4;
  logic [`XLEN-1:0] pcTarget;
  logic [`XLEN-1:0] nextPc;

  ctrlT             ctrl;

  logic [`XLEN-1:0] aData;
  logic [`XLEN-1:0] bData;
  logic [`XLEN-1:0] aluB;
  logic [`XLEN-1:0] aluResult;
  logic             isEqual;
  logic             branchTaken;

  logic [`XLEN-1:0] wbData;
  logic             wrEn;

  // Decode the fetched word
  instrDecoder uDecoder (
    .instr (instr),
    .ctrl  (ctrl)
  );

  regFile uRegFile (
    .clk      (clk),
    .rst      (rst),
    .regWrite (wrEn),
    .regW     (ctrl.rd),
    .wData    (wbData),
    .regA     (ctrl.rs1),
    .regB     (ctrl.rs2),
    .aData    (aData),
    .bData    (bData),
    .regTest  (testReg),
    .testData (testData)
  );

  // Operand B is rs2 or the immediate
  assign aluB = ctrl.useImm ? ctrl.imm : bData;

  aluUnit uAlu (
    .opA     (aData),
    .opB     (aluB),
    .aluOp   (ctrl.aluOp),
    .result  (aluResult),
    .isEqual (isEqual)
  );

  // Next PC
  assign pcPlus4  = pc + `XLEN'd4;
  assign pcTarget = pc + ctrl.imm;

  // BEQ taken on equal, BNE taken on not equal
  assign branchTaken = ctrl.isBranch && (isEqual ^ ctrl.branchNe);

  assign nextPc = (ctrl.isJal || branchTaken) ? pcTarget : pcPlus4;

  // PC holds while run is low
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else if (run) begin
      pc <= nextPc;
    end
  end

  assign instrAddr = pc;

  // Writeback
  // JAL links PC+4, LUI arrives through PASSB as an ALU result
  assign wbData = ctrl.isJal ? pcPlus4 : aluResult;

  // Write strobe, quiet in reset, when stalled or on an illegal opcode
  assign wrEn = run && !rst && ctrl.regWrite && !ctrl.illegal;

  assign illegalSeen = ctrl.illegal;

endmodule

`default_nettype wire

// ==== verilog/rvCtrlPkg.sv ====
// Control types produced by the decoder
// ALU operation codes and the decoded control bundle

`default_nettype none

`include "rvParams.svh"

package rvCtrlPkg;

  // ALU operations, PASSB forwards operand B for LUI
  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_AND   = 4'd2,
    ALU_OR    = 4'd3,
    ALU_XOR   = 4'd4,
    ALU_SLL   = 4'd5,
    ALU_SRL   = 4'd6,
    ALU_SRA   = 4'd7,
    ALU_SLT   = 4'd8,
    ALU_SLTU  = 4'd9,
    ALU_PASSB = 4'd10
  } aluOpE;

  // Everything the datapath needs from one instruction
  typedef struct packed {
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       imm;
    aluOpE                  aluOp;
    logic                   useImm;
    logic                   regWrite;
    logic                   isBranch;
    logic                   branchNe;
    logic                   isJal;
    logic                   illegal;
  } ctrlT;

endpackage

`default_nettype wire

// ==== verilog/rvIsaPkg.sv ====
// ISA encodings of the supported RV32I subset
// Opcodes, funct3 codes and the instruction word union

`default_nettype none

package rvIsaPkg;

  // Major opcodes that the core executes
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcodeE;

  // ALU funct3 values, shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Branch funct3 values
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // Field views, msb first as in the ISA manual
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcodeE     opcode;
  } rFmtT;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcodeE      opcode;
  } iFmtT;

  // Branch offset is scattered over two fields
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcodeE     opcode;
  } bFmtT;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    opcodeE      opcode;
  } uFmtT;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcodeE     opcode;
  } jFmtT;

  // One instruction word, read through whichever format applies
  typedef union packed {
    rFmtT rType;
    iFmtT iType;
    bFmtT bType;
    uFmtT uType;
    jFmtT jType;
  } instrU;

endpackage

`default_nettype wire

// ==== verilog/rvParams.svh ====
// Global size macros for the core
// Word width, register file geometry and reset vector

`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data word width
`define XLEN 32

// Number of architectural registers
`define REG_COUNT 32

// Bits needed to index one register
`define REG_ADDR_W 5

// PC value loaded on reset
`define RESET_PC 32'h0000_0000

`endif
